// File: Makefile
VERILATOR  ?= verilator
TOP        := radio_block_tb
RTL_TOP    := radio_block
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/radio_regs.svh
////////////////////
// Radio block register map
// Settings and readback offsets per target
////////////////////

`ifndef RADIO_REGS_SVH
`define RADIO_REGS_SVH

// Timekeeper settings
`define SR_TIME_HI      6'd0
`define SR_TIME_LO      6'd1
`define SR_TIME_CTRL    6'd2
// Set to load at next PPS, clear to load now
`define TIME_CTRL_PPS   0

// Timekeeper readbacks
`define RB_TIME_LO      6'd3
`define RB_TIME_HI      6'd4
`define RB_PPS_LO       6'd5
`define RB_PPS_HI       6'd6

// Radio settings and control bits
`define SR_CTRL         6'd0
`define SR_TX_WORD      6'd1
`define CTRL_RX_EN      0
`define CTRL_TX_EN      1
`define CTRL_IQ_SWAP    2

// Radio readbacks
`define RB_RX_COUNT     6'd8
`define RB_RX_LAST      6'd9
`define RB_RX_TIME_LO   6'd10
`define RB_TX_COUNT     6'd11

`endif

// File: sources.f
+incdir+include
verilog/radio_pkg.sv
verilog/timekeeper.sv
verilog/radio_core.sv
verilog/radio_regport.sv
verilog/radio_block.sv
test/radio_block_properties.sv
test/radio_block_tb.sv

// File: test/radio_block_properties.sv
////////////////////
// Register port checks
// Wishbone handshake and settings strobe rules
////////////////////

`timescale 1ns/1ps

module radio_block_properties (
  input logic       i_ce_clk,
  input logic       i_rst,
  input logic       i_wb_cyc,
  input logic       i_wb_stb,
  input logic       o_wb_ack,
  input logic [2:0] o_set_stb
);

  // Failed assertions so far
  int fail_count = 0;

  ack_one_cycle: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    o_wb_ack |=> !o_wb_ack)
    else begin
      $error("acknowledge stayed high for two cycles");
      fail_count++;
    end

  // Ack only in the cycle after the host held cycle and strobe
  ack_after_req: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin
      $error("acknowledge without a request");
      fail_count++;
    end

  set_stb_onehot: assert property (@(posedge i_ce_clk) disable iff (i_rst)
    $onehot0(o_set_stb))
    else begin
      $error("more than one settings strobe high");
      fail_count++;
    end

endmodule

bind radio_regport radio_block_properties u_props (
  .i_ce_clk(i_ce_clk), .i_rst(i_rst), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
  .o_wb_ack(o_wb_ack), .o_set_stb(o_set_stb));

// File: test/radio_block_tb.sv
////////////////////
// Radio block testbench
// Directed tests of host access, time, receive and transmit
////////////////////

`timescale 1ns/1ps

module radio_block_tb;

  `include "radio_regs.svh"

  localparam int COUNT_W = 32;
  localparam logic [radio_pkg::SEL_W-1:0] UNMAPPED_SEL = 2'd3;

  // Rough cycle cost of reset and of each test, in order
  localparam int TEST_CYCLES = 8 + 50 + 60 + 90 + 230 + 100 + 80;
  localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

  logic                         clk;
  logic                         rst;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [radio_pkg::ADDR_W-1:0] wb_adr;
  logic [radio_pkg::DATA_W-1:0] wb_dat_w;
  logic [radio_pkg::DATA_W-1:0] wb_dat_r;
  logic                         wb_ack;
  logic                         pps;
  logic [63:0]                  rx;
  logic [1:0]                   rx_stb;
  logic [1:0]                   tx_stb;
  logic [63:0]                  tx;

  int                 errors;
  int                 cycle_count = 0;
  integer             seed;
  logic [63:0]        time_model;
  logic [2:0]         ctrl_model [2];
  radio_pkg::sample_u tx_word_model [2];
  radio_pkg::sample_u exp_tx [2];
  int                 exp_tx_count [2];
  int                 exp_rx_count [2];
  radio_pkg::sample_u exp_rx_last [2];
  logic [31:0]        exp_rx_time [2];

  radio_block #(.COUNT_W(COUNT_W)) uut (
    .i_ce_clk(clk), .i_rst(rst),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
    .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w),
    .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack),
    .i_pps(pps), .i_rx(rx), .i_rx_stb(rx_stb),
    .i_tx_stb(tx_stb), .o_tx(tx));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_word(input logic [radio_pkg::DATA_W-1:0] got,
                            input logic [radio_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_sample(input radio_pkg::sample_u got,
                              input radio_pkg::sample_u exp, input string what);
    if (got.raw !== exp.raw) begin
      $display("ERROR at %0t: %s is I=%h Q=%h, expected I=%h Q=%h", $time, what,
               got.iq.i, got.iq.q, exp.iq.i, exp.iq.q);
      errors++;
    end
  endtask

  function automatic logic [radio_pkg::ADDR_W-1:0] make_addr(
      input logic [radio_pkg::SEL_W-1:0] sel, input logic [radio_pkg::REG_W-1:0] off);
    return {sel, off};
  endfunction

  function automatic logic [radio_pkg::SEL_W-1:0] radio_sel(input int ch);
    return (ch == 0) ? radio_pkg::SEL_RADIO0 : radio_pkg::SEL_RADIO1;
  endfunction

  // I and Q change places
  function automatic radio_pkg::sample_u swap_halves(input radio_pkg::sample_u s);
    radio_pkg::sample_u r;
    r.raw = {s.raw[15:0], s.raw[31:16]};
    return r;
  endfunction

  ////////////////////
  // Host and sample drivers
  ////////////////////

  // Ack is due in the cycle right after the request cycle
  task automatic wb_transfer(input logic we, input logic [radio_pkg::ADDR_W-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < 16);
    if (!wb_ack) begin
      $display("No acknowledge came from the DUT for address %h", adr);
      errors++;
    end else if (n != 2) begin
      $display("ERROR at %0t: ack for address %h came %0d cycles after the request",
               $time, adr, n - 1);
      errors++;
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [radio_pkg::ADDR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_transfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [radio_pkg::ADDR_W-1:0] adr, output logic [31:0] data);
    wb_transfer(1'b0, adr, 32'd0, data);
  endtask

  task automatic read_and_check(input logic [radio_pkg::ADDR_W-1:0] adr,
                                input logic [31:0] exp, input string what);
    logic [31:0] data;
    wb_read(adr, data);
    check_word(data, exp, what);
  endtask

  task automatic set_ctrl(input int ch, input logic [2:0] val);
    wb_write(make_addr(radio_sel(ch), `SR_CTRL), {29'd0, val});
    ctrl_model[ch] = val;
  endtask

  task automatic set_tx_word(input int ch, input logic [31:0] word);
    wb_write(make_addr(radio_sel(ch), `SR_TX_WORD), word);
    tx_word_model[ch].raw = word;
  endtask

  // One receive sample, channel 0 also ticks the radio time
  task automatic rx_pulse(input int ch, input logic [31:0] data);
    radio_pkg::sample_u s;
    s.raw = data;
    @(posedge clk);
    rx[ch*32 +: 32] <= data;
    rx_stb[ch]      <= 1'b1;
    @(posedge clk);
    rx_stb[ch] <= 1'b0;
    if (ctrl_model[ch][`CTRL_RX_EN]) begin
      exp_rx_count[ch]++;
      exp_rx_last[ch] = ctrl_model[ch][`CTRL_IQ_SWAP] ? swap_halves(s) : s;
      exp_rx_time[ch] = time_model[31:0];
    end
    if (ch == 0)
      time_model = time_model + 64'd1;
  endtask

  task automatic tx_pulse(input int ch);
    @(posedge clk);
    tx_stb[ch] <= 1'b1;
    @(posedge clk);
    tx_stb[ch] <= 1'b0;
    if (ctrl_model[ch][`CTRL_TX_EN]) begin
      exp_tx[ch] = ctrl_model[ch][`CTRL_IQ_SWAP] ? swap_halves(tx_word_model[ch])
                                                 : tx_word_model[ch];
      exp_tx_count[ch]++;
    end else begin
      exp_tx[ch].raw = 32'd0;
    end
    @(negedge clk);
    check_sample(tx[31:0], exp_tx[0], "channel 0 transmit");
    check_sample(tx[63:32], exp_tx[1], "channel 1 transmit");
  endtask

  task automatic check_time();
    read_and_check(make_addr(radio_pkg::SEL_TIME, `RB_TIME_LO), time_model[31:0], "time lo");
    read_and_check(make_addr(radio_pkg::SEL_TIME, `RB_TIME_HI), time_model[63:32], "time hi");
  endtask

  task automatic check_counts(input int ch);
    read_and_check(make_addr(radio_sel(ch), `RB_RX_COUNT), exp_rx_count[ch],
                   $sformatf("radio %0d rx count", ch));
    read_and_check(make_addr(radio_sel(ch), `RB_TX_COUNT), exp_tx_count[ch],
                   $sformatf("radio %0d tx count", ch));
  endtask

  task automatic check_capture(input int ch);
    logic [31:0] data;
    wb_read(make_addr(radio_sel(ch), `RB_RX_LAST), data);
    check_sample(data, exp_rx_last[ch], $sformatf("radio %0d last rx", ch));
    read_and_check(make_addr(radio_sel(ch), `RB_RX_TIME_LO), exp_rx_time[ch],
                   $sformatf("radio %0d rx time", ch));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_register_access();
    set_ctrl(0, 3'b010);
    set_ctrl(1, 3'b110);
    set_tx_word(0, 32'h1111_2222);
    set_tx_word(1, 32'h3333_4444);
    tx_pulse(0);
    check_counts(0);
    check_counts(1);
    tx_pulse(1);
    check_counts(0);
    check_counts(1);
  endtask

  // Low word wraps so the high word moves too
  task automatic test_load_now();
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_HI), 32'h0000_0012);
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_LO), 32'hffff_fff8);
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_CTRL), 32'd0);
    time_model = 64'h0000_0012_ffff_fff8;
    check_time();
    repeat (12) rx_pulse(0, $random(seed));
    check_time();
  endtask

  task automatic test_load_at_pps();
    logic [63:0] edge_time;
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_HI), 32'd0);
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_LO), 32'h0000_1000);
    wb_write(make_addr(radio_pkg::SEL_TIME, `SR_TIME_CTRL), 32'd1);
    repeat (5) rx_pulse(0, $random(seed));
    check_time();
    for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      pps <= 1'b1;
      @(posedge clk);
      pps <= 1'b0;
      edge_time = time_model;
      // Only the first edge after arming reloads
      if (k == 0)
        time_model = 64'h0000_0000_0000_1000;
      repeat (3) rx_pulse(0, $random(seed));
      check_time();
      read_and_check(make_addr(radio_pkg::SEL_TIME, `RB_PPS_LO), edge_time[31:0], "pps lo");
      read_and_check(make_addr(radio_pkg::SEL_TIME, `RB_PPS_HI), edge_time[63:32], "pps hi");
    end
  endtask

  // Enabled, enabled with swap, then off and off with swap
  task automatic test_rx_capture();
    for (int ch = 0; ch < 2; ch++) begin
      for (int c = 0; c < 4; c++) begin
        set_ctrl(ch, {c[0], 1'b0, ~c[1]});
        repeat (4) rx_pulse(ch, $random(seed));
        check_counts(ch);
        check_capture(ch);
      end
    end
  endtask

  task automatic test_tx();
    for (int ch = 0; ch < 2; ch++) begin
      for (int c = 0; c < 3; c++) begin
        set_tx_word(ch, $random(seed));
        set_ctrl(ch, (c == 0) ? 3'b010 : (c == 1) ? 3'b110 : 3'b000);
        repeat (2) tx_pulse(ch);
      end
    end
    check_counts(0);
    check_counts(1);
  endtask

  task automatic test_unmapped();
    read_and_check(make_addr(UNMAPPED_SEL, `RB_TIME_LO), 32'd0, "unmapped time lo");
    read_and_check(make_addr(UNMAPPED_SEL, `RB_RX_COUNT), 32'd0, "unmapped rx count");
    read_and_check(make_addr(UNMAPPED_SEL, `RB_TX_COUNT), 32'd0, "unmapped tx count");
    wb_write(make_addr(UNMAPPED_SEL, `SR_TIME_CTRL), 32'd0);
    wb_write(make_addr(UNMAPPED_SEL, `SR_CTRL), 32'h7);
    wb_write(make_addr(UNMAPPED_SEL, `SR_TX_WORD), 32'hdead_beef);
    check_time();
    for (int ch = 0; ch < 2; ch++) begin
      check_counts(ch);
      check_capture(ch);
      rx_pulse(ch, $random(seed));
      tx_pulse(ch);
      check_counts(ch);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int total;
    seed     = 11;
    errors   = 0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    pps      = 1'b0;
    rx       = '0;
    rx_stb   = 2'b00;
    tx_stb   = 2'b00;
    time_model = '0;
    for (int ch = 0; ch < 2; ch++) begin
      ctrl_model[ch]   = 3'b000;
      exp_tx[ch].raw   = 32'd0;
      exp_tx_count[ch] = 0;
      exp_rx_count[ch] = 0;
    end

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_register_access();
    test_load_now();
    test_load_at_pps();
    test_rx_capture();
    test_tx();
    test_unmapped();

    total = errors + uut.radio_regport.u_props.fail_count;
    $display("Errors: %0d check failures, %0d assertion failures", errors,
             uut.radio_regport.u_props.fail_count);
    if (total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verilog/radio_block.sv
////////////////////
// Two-channel radio block
// Register port, shared timekeeper and two radio cores
////////////////////

`timescale 1ns/1ps

module radio_block #(
  parameter int COUNT_W = 32
) (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [radio_pkg::ADDR_W-1:0] i_wb_adr,
  input  logic [radio_pkg::DATA_W-1:0] i_wb_dat,
  output logic [radio_pkg::DATA_W-1:0] o_wb_dat,
  output logic                        o_wb_ack,
  input  logic                        i_pps,
  input  logic [63:0]                 i_rx,
  input  logic [1:0]                  i_rx_stb,
  input  logic [1:0]                  i_tx_stb,
  output logic [63:0]                 o_tx
);

  logic [2:0]                    set_stb;
  logic [radio_pkg::REG_W-1:0]   set_addr;
  logic [radio_pkg::DATA_W-1:0]  set_data;
  logic [2:0]                    rb_stb;
  logic [radio_pkg::DATA_W-1:0]  rb_data_time;
  logic [radio_pkg::DATA_W-1:0]  rb_data_radio0;
  logic [radio_pkg::DATA_W-1:0]  rb_data_radio1;
  logic [63:0]                   vita_time;

  ////////////////////
  // Host side
  ////////////////////

  radio_regport radio_regport (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
    .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
    .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
    .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
    .o_rb_stb(rb_stb),
    .i_rb_data_time(rb_data_time),
    .i_rb_data_radio0(rb_data_radio0),
    .i_rb_data_radio1(rb_data_radio1));

  // Time advances on the channel 0 sample strobe
  timekeeper timekeeper (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst), .i_pps(i_pps), .i_strobe(i_rx_stb[0]),
    .i_set_stb(set_stb[0]), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_stb(rb_stb[0]), .i_rb_addr(set_addr), .o_rb_data(rb_data_time),
    .o_vita_time(vita_time), .o_vita_time_lastpps());

  ////////////////////
  // Radio channels
  ////////////////////

  radio_core #(.COUNT_W(COUNT_W)) radio_core0 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_set_stb(set_stb[1]), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_addr(set_addr), .o_rb_data(rb_data_radio0),
    .i_vita_time(vita_time),
    .i_rx(i_rx[31:0]), .i_rx_stb(i_rx_stb[0]),
    .o_tx(o_tx[31:0]), .i_tx_stb(i_tx_stb[0]));

  radio_core #(.COUNT_W(COUNT_W)) radio_core1 (
    .i_ce_clk(i_ce_clk), .i_rst(i_rst),
    .i_set_stb(set_stb[2]), .i_set_addr(set_addr), .i_set_data(set_data),
    .i_rb_addr(set_addr), .o_rb_data(rb_data_radio1),
    .i_vita_time(vita_time),
    .i_rx(i_rx[63:32]), .i_rx_stb(i_rx_stb[1]),
    .o_tx(o_tx[63:32]), .i_tx_stb(i_tx_stb[1]));

endmodule

// File: verilog/radio_core.sv
////////////////////
// Radio core
// Receive capture, transmit drive, control and readback
////////////////////

`timescale 1ns/1ps

module radio_core #(
  parameter int COUNT_W = 32
) (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_set_stb,
  input  logic [radio_pkg::REG_W-1:0]  i_set_addr,
  input  logic [radio_pkg::DATA_W-1:0] i_set_data,
  input  logic [radio_pkg::REG_W-1:0]  i_rb_addr,
  output logic [radio_pkg::DATA_W-1:0] o_rb_data,
  input  logic [63:0]                 i_vita_time,
  input  logic [31:0]                 i_rx,
  input  logic                        i_rx_stb,
  output logic [31:0]                 o_tx,
  input  logic                        i_tx_stb
);

  `include "radio_regs.svh"

  localparam int DW = radio_pkg::DATA_W;

  logic [2:0]              ctrl;
  logic                    rx_en;
  logic                    tx_en;
  logic                    iq_swap;
  radio_pkg::sample_u      tx_word;
  radio_pkg::sample_u      rx_in;
  radio_pkg::sample_u      rx_sample;
  radio_pkg::sample_u      tx_sample;
  logic [COUNT_W-1:0]      rx_count;
  logic [COUNT_W-1:0]      tx_count;
  radio_pkg::sample_u      rx_last;
  logic [31:0]             rx_time_lo;

  // Exchange the I and Q halves
  function automatic radio_pkg::sample_u swap_iq(input radio_pkg::sample_u s);
    radio_pkg::sample_u r;
    r.iq.i = s.iq.q;
    r.iq.q = s.iq.i;
    return r;
  endfunction

  assign rx_en   = ctrl[`CTRL_RX_EN];
  assign tx_en   = ctrl[`CTRL_TX_EN];
  assign iq_swap = ctrl[`CTRL_IQ_SWAP];

  assign rx_in.raw = i_rx;
  assign rx_sample = iq_swap ? swap_iq(rx_in) : rx_in;
  assign tx_sample = iq_swap ? swap_iq(tx_word) : tx_word;

  ////////////////////
  // Settings
  ////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_rst)
      ctrl <= 3'b000;
    else if (i_set_stb && (i_set_addr == `SR_CTRL))
      ctrl <= i_set_data[2:0];
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_set_stb && (i_set_addr == `SR_TX_WORD))
      tx_word.raw <= i_set_data;
  end

  ////////////////////
  // Receive and transmit
  ////////////////////

  // Last sample and its time
  always_ff @(posedge i_ce_clk) begin
    if (i_rx_stb && rx_en) begin
      rx_last    <= rx_sample;
      rx_time_lo <= i_vita_time[31:0];
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      rx_count <= '0;
      tx_count <= '0;
      o_tx     <= '0;
    end else begin
      if (i_rx_stb && rx_en)
        rx_count <= rx_count + 1'b1;
      // Output holds between strobes, zero while transmit is off
      if (i_tx_stb) begin
        o_tx <= tx_en ? tx_sample.raw : 32'd0;
        if (tx_en)
          tx_count <= tx_count + 1'b1;
      end
    end
  end

  // Readback mux
  always_comb begin
    case (i_rb_addr)
      `RB_RX_COUNT:   o_rb_data = DW'(rx_count);
      `RB_RX_LAST:    o_rb_data = rx_last.raw;
      `RB_RX_TIME_LO: o_rb_data = rx_time_lo;
      `RB_TX_COUNT:   o_rb_data = DW'(tx_count);
      default:        o_rb_data = '0;
    endcase
  end

endmodule

// File: verilog/radio_pkg.sv
////////////////////
// Radio block shared definitions
// Bus widths, target selects and the sample word
////////////////////

package radio_pkg;

  ////////////////////
  // Host bus
  ////////////////////

  // Wishbone word address and data widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Register offset inside one target
  localparam int REG_W = 6;

  // Target select sits in the top address bits
  localparam int SEL_W = ADDR_W - REG_W;

  localparam logic [SEL_W-1:0] SEL_TIME   = 2'd0;
  localparam logic [SEL_W-1:0] SEL_RADIO0 = 2'd1;
  localparam logic [SEL_W-1:0] SEL_RADIO1 = 2'd2;
  // Select 3 is left unmapped and reads zero

  ////////////////////
  // Sample word
  ////////////////////

  // I in the upper half, Q in the lower half
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } iq_t;

  // One 32-bit word, seen as raw bits or as an I/Q pair
  typedef union packed {
    logic [31:0] raw;
    iq_t         iq;
  } sample_u;

endpackage

// File: verilog/radio_regport.sv
////////////////////
// Radio register port
// Wishbone classic slave, settings strobes and readback merge
////////////////////

`timescale 1ns/1ps

module radio_regport (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_wb_cyc,
  input  logic                        i_wb_stb,
  input  logic                        i_wb_we,
  input  logic [radio_pkg::ADDR_W-1:0] i_wb_adr,
  input  logic [radio_pkg::DATA_W-1:0] i_wb_dat,
  output logic [radio_pkg::DATA_W-1:0] o_wb_dat,
  output logic                        o_wb_ack,
  output logic [2:0]                  o_set_stb,
  output logic [radio_pkg::REG_W-1:0]  o_set_addr,
  output logic [radio_pkg::DATA_W-1:0] o_set_data,
  output logic [2:0]                  o_rb_stb,
  input  logic [radio_pkg::DATA_W-1:0] i_rb_data_time,
  input  logic [radio_pkg::DATA_W-1:0] i_rb_data_radio0,
  input  logic [radio_pkg::DATA_W-1:0] i_rb_data_radio1
);

  logic                          req;
  logic [radio_pkg::SEL_W-1:0]   sel;
  logic [2:0]                    sel_hot;
  logic [radio_pkg::DATA_W-1:0]  rb_merge;

  // New transfer when the slave is not already acknowledging
  assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign sel = i_wb_adr[radio_pkg::ADDR_W-1 -: radio_pkg::SEL_W];

  // The host holds address and data until it sees acknowledge
  assign o_set_addr = i_wb_adr[radio_pkg::REG_W-1:0];
  assign o_set_data = i_wb_dat;

  ////////////////////
  // Target decode
  ////////////////////

  always_comb begin
    case (sel)
      radio_pkg::SEL_TIME: begin
        sel_hot  = 3'b001;
        rb_merge = i_rb_data_time;
      end
      radio_pkg::SEL_RADIO0: begin
        sel_hot  = 3'b010;
        rb_merge = i_rb_data_radio0;
      end
      radio_pkg::SEL_RADIO1: begin
        sel_hot  = 3'b100;
        rb_merge = i_rb_data_radio1;
      end
      default: begin
        sel_hot  = 3'b000;
        rb_merge = '0;
      end
    endcase
  end

  // Read strobe in the request cycle, lined up with the sampled reply
  assign o_rb_stb = (req && !i_wb_we) ? sel_hot : 3'b000;

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      o_wb_ack  <= 1'b0;
      o_set_stb <= 3'b000;
    end else begin
      o_wb_ack  <= req;
      o_set_stb <= (req && i_wb_we) ? sel_hot : 3'b000;
    end
  end

  // Reply registered from the request cycle
  always_ff @(posedge i_ce_clk) begin
    if (req)
      o_wb_dat <= rb_merge;
  end

endmodule

// File: verilog/timekeeper.sv
////////////////////
// Radio timekeeper
// Settable 64-bit radio time with PPS load and PPS capture
////////////////////

`timescale 1ns/1ps

module timekeeper (
  input  logic                        i_ce_clk,
  input  logic                        i_rst,
  input  logic                        i_pps,
  input  logic                        i_strobe,
  input  logic                        i_set_stb,
  input  logic [radio_pkg::REG_W-1:0]  i_set_addr,
  input  logic [radio_pkg::DATA_W-1:0] i_set_data,
  input  logic                        i_rb_stb,
  input  logic [radio_pkg::REG_W-1:0]  i_rb_addr,
  output logic [radio_pkg::DATA_W-1:0] o_rb_data,
  output logic [63:0]                 o_vita_time,
  output logic [63:0]                 o_vita_time_lastpps
);

  `include "radio_regs.svh"

  logic [31:0] time_hi_pend;
  logic [31:0] time_lo_pend;
  logic        load_pps;
  logic        pps_d;
  logic        pps_rise;
  logic        ctrl_wr;
  logic        load_now;
  logic [31:0] time_hi_snap;

  assign pps_rise = i_pps & ~pps_d;
  assign ctrl_wr  = i_set_stb && (i_set_addr == `SR_TIME_CTRL);
  assign load_now = ctrl_wr && !i_set_data[`TIME_CTRL_PPS];

  // Pending time words and the upper-word snapshot
  always_ff @(posedge i_ce_clk) begin
    if (i_set_stb && (i_set_addr == `SR_TIME_HI))
      time_hi_pend <= i_set_data;
    if (i_set_stb && (i_set_addr == `SR_TIME_LO))
      time_lo_pend <= i_set_data;
    // Keeps the upper word consistent with the low word just read
    if (i_rb_stb && (i_rb_addr == `RB_TIME_LO))
      time_hi_snap <= o_vita_time[63:32];
  end

  ////////////////////
  // Running time
  ////////////////////

  always_ff @(posedge i_ce_clk) begin
    if (i_rst) begin
      pps_d               <= 1'b0;
      load_pps            <= 1'b0;
      o_vita_time         <= '0;
      o_vita_time_lastpps <= '0;
    end else begin
      pps_d <= i_pps;

      if (pps_rise)
        o_vita_time_lastpps <= o_vita_time;

      // Arm or disarm the load at PPS
      if (ctrl_wr)
        load_pps <= i_set_data[`TIME_CTRL_PPS];
      else if (load_pps && pps_rise)
        load_pps <= 1'b0;

      if (load_now || (load_pps && pps_rise))
        o_vita_time <= {time_hi_pend, time_lo_pend};
      else if (i_strobe)
        o_vita_time <= o_vita_time + 64'd1;
    end
  end

  // Readback mux
  always_comb begin
    case (i_rb_addr)
      `RB_TIME_LO: o_rb_data = o_vita_time[31:0];
      `RB_TIME_HI: o_rb_data = time_hi_snap;
      `RB_PPS_LO:  o_rb_data = o_vita_time_lastpps[31:0];
      `RB_PPS_HI:  o_rb_data = o_vita_time_lastpps[63:32];
      default:     o_rb_data = '0;
    endcase
  end

endmodule
